// File: project.f
source/icache_pkg.sv
source/icb_pkg.sv
source/icache_route.sv
source/icache_lookup.sv
source/icache_refill.sv
source/icache_data.sv
source/icache_top.sv
testbench/icb_mem_model.sv
testbench/icache_asserts.sv
testbench/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icb_pkg.sv
  - source/icache_route.sv
  - source/icache_lookup.sv
  - source/icache_refill.sv
  - source/icache_data.sv
  - source/icache_top.sv
  - target: test
    files:
      - testbench/icb_mem_model.sv
      - testbench/icache_asserts.sv
      - testbench/icache_tb.sv

// File: testbench/icache_tb.sv
`timescale 1ns/100ps
module icache_tb;

    localparam int timeout_cycles = 300;
    localparam int num_rows       = 20;

    // one fetch per row
    typedef struct {
        logic [icb_pkg::addr_w-1:0] addr;
        logic                       err;   // expected rsp_err
        int                         reads; // bus reads this fetch adds
        logic                       hold;  // random rsp_ready stalls
    } row_t;

    logic                        clk, rstn;
    logic                        cmd_valid, cmd_ready;
    logic [icb_pkg::addr_w-1:0]  cmd_addr;
    logic                        rsp_valid, rsp_ready, rsp_err;
    logic [icb_pkg::word_w-1:0]  rsp_rdata;
    logic                        bus_cmd_valid, bus_cmd_ready;
    logic [icb_pkg::addr_w-1:0]  bus_cmd_addr;
    logic                        bus_rsp_valid, bus_rsp_err;
    logic [icb_pkg::bus_dw-1:0]  bus_rsp_rdata;
    int                          read_count;
    row_t                        rows [num_rows];
    logic [31:0]                 rng;
    logic [icb_pkg::addr_w-1:0]  bus_addrs [$]; // bus reads seen for the current row
    int                          data_errs, flag_errs, read_errs, addr_errs;
    int                          reset_errs, timeouts;

    icache_top    UUT   (.*);
    icb_mem_model u_mem (.*);

    bind icache_route icache_asserts u_checks (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // word at A holds ~A
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return ~{a[31:2], 2'b00};
    endfunction

    ////////////////////
    // stimulus table
    ////////////////////
    task automatic fill_rows();
        rows[0]  = '{32'h0000_2000, 1'b0, 4, 1'b0}; // cold miss in set 0
        rows[1]  = '{32'h0000_2014, 1'b0, 0, 1'b0}; // same line hit
        rows[2]  = '{32'h0000_0800, 1'b0, 1, 1'b0}; // uncached low half
        rows[3]  = '{32'h0000_0804, 1'b0, 1, 1'b0}; // uncached high half
        rows[4]  = '{32'h0001_0040, 1'b0, 4, 1'b0}; // five tags into set 2
        rows[5]  = '{32'h0001_1044, 1'b0, 4, 1'b0};
        rows[6]  = '{32'h0001_2048, 1'b0, 4, 1'b0};
        rows[7]  = '{32'h0001_304C, 1'b0, 4, 1'b0};
        rows[8]  = '{32'h0001_4050, 1'b0, 4, 1'b0}; // evicts the first
        rows[9]  = '{32'h0001_005C, 1'b0, 4, 1'b0}; // first line refetched
        rows[10] = '{32'hF000_0100, 1'b1, 4, 1'b0}; // faulting line
        rows[11] = '{32'hF000_0108, 1'b1, 4, 1'b0}; // not cached so misses again
        rows[12] = '{32'h0000_0100, 1'b0, 1, 1'b1}; // mixed paths with core stalls
        rows[13] = '{32'h0000_2004, 1'b0, 0, 1'b1};
        rows[14] = '{32'h0000_0104, 1'b0, 1, 1'b1};
        rows[15] = '{32'h0000_3008, 1'b0, 4, 1'b1};
        rows[16] = '{32'h0000_0FF8, 1'b0, 1, 1'b1};
        rows[17] = '{32'h0000_300C, 1'b0, 0, 1'b1};
        rows[18] = '{32'h0000_0FFC, 1'b0, 1, 1'b1};
        rows[19] = '{32'h0000_201C, 1'b0, 0, 1'b1};
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("[FAIL] %s after reset: got %h expected 0", name, value);
            reset_errs++;
        end
    endtask

    // entered and left on a falling edge
    task automatic send_cmd(input logic [31:0] addr, output logic ok);
        int   t;
        logic took;
        t         = 0;
        took      = 1'b0;
        cmd_valid = 1'b1;
        cmd_addr  = addr;
        while (!took && t < timeout_cycles) begin
            #1;
            took = cmd_ready; // transfer on the coming rising edge
            @(negedge clk);
            t++;
        end
        cmd_valid = 1'b0;
        ok        = took;
        if (!took) begin
            $display("timeout: fetch command %h was never accepted", addr);
            timeouts++;
        end
    endtask

    task automatic take_rsp(input logic hold, output logic [31:0] data,
                            output logic err, output logic ok);
        int   t;
        logic done;
        t    = 0;
        done = 1'b0;
        data = '0;
        err  = 1'b0;
        while (!done && t < timeout_cycles) begin
            if (hold) begin
                rng       = lcg_step(rng);
                rsp_ready = (rng[18:16] > 3'd2);
            end else begin
                rsp_ready = 1'b1;
            end
            #1;
            if (rsp_valid && rsp_ready) begin
                data = rsp_rdata;
                err  = rsp_err;
                done = 1'b1;
            end
            @(negedge clk);
            t++;
        end
        rsp_ready = 1'b0;
        ok        = done;
        if (!done) begin
            $display("timeout: no fetch response arrived");
            timeouts++;
        end
    endtask

    // bus read addresses, same sampling point as the memory model
    always @(posedge clk) begin
        if (rstn && bus_cmd_valid && bus_cmd_ready)
            bus_addrs.push_back(bus_cmd_addr);
    end

    ////////////////////
    // clock and run
    ////////////////////
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [31:0] got_data, exp_addr;
        logic        got_err, ok;
        int          reads_before, total;
        data_errs  = 0;
        flag_errs  = 0;
        read_errs  = 0;
        addr_errs  = 0;
        reset_errs = 0;
        timeouts   = 0;
        rng        = 32'd90;
        rstn       = 1'b0;
        cmd_valid  = 1'b0;
        cmd_addr   = 32'h0000_2000; // cacheable, so a wrong mode would show on cmd_ready
        rsp_ready  = 1'b0;
        fill_rows();
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_low("cmd_ready", cmd_ready);
        expect_low("rsp_valid", rsp_valid);
        expect_low("bus_cmd_valid", bus_cmd_valid);
        rstn = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_rows; i++) begin
            reads_before = read_count;
            bus_addrs.delete();
            send_cmd(rows[i].addr, ok);
            if (ok)
                take_rsp(rows[i].hold, got_data, got_err, ok);
            if (!ok)
                break;
            if (got_err !== rows[i].err) begin
                $display("[FAIL] row %0d rsp_err: got %h expected %h",
                         i, got_err, rows[i].err);
                flag_errs++;
            end
            if (!rows[i].err && got_data !== word_at(rows[i].addr)) begin
                $display("[FAIL] row %0d rsp_rdata: got %h expected %h",
                         i, got_data, word_at(rows[i].addr));
                data_errs++;
            end
            if (read_count - reads_before != rows[i].reads) begin
                $display("[FAIL] row %0d bus reads (read_count delta): got %h expected %h",
                         i, read_count - reads_before, rows[i].reads);
                read_errs++;
            end
            // one aligned beat when uncached, else the line in beat order
            for (int k = 0; k < bus_addrs.size(); k++) begin
                if (rows[i].reads == 1)
                    exp_addr = {rows[i].addr[31:3], 3'b000};
                else
                    exp_addr = {rows[i].addr[31:5], 5'b00000} + 32'(k * 8);
                if (bus_addrs[k] !== exp_addr) begin
                    $display("[FAIL] row %0d bus_cmd_addr: got %h expected %h",
                             i, bus_addrs[k], exp_addr);
                    addr_errs++;
                end
            end
        end

        total = data_errs + flag_errs + read_errs + addr_errs + reset_errs + timeouts
              + UUT.u_route.u_checks.violations;
        $display("errors: data %0d flag %0d reads %0d addr %0d reset %0d timeout %0d assert %0d",
                 data_errs, flag_errs, read_errs, addr_errs, reset_errs, timeouts,
                 UUT.u_route.u_checks.violations);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: testbench/icache_asserts.sv
`timescale 1ns/100ps
module icache_asserts (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        bus_cmd_valid,
    input  logic                        bus_cmd_ready,
    input  logic [icb_pkg::addr_w-1:0]  bus_cmd_addr,
    input  logic                        rsp_valid,
    input  logic                        rsp_ready,
    input  logic                        rsp_err,
    input  icache_pkg::route_state_e    mode,
    input  logic [icb_pkg::out_w-1:0]   out_cnt
);

    int violations = 0; // read by the testbench at the end

    // bus command waits for the slave
    bus_hold: assert property (@(posedge clk) disable iff (!rstn)
        bus_cmd_valid && !bus_cmd_ready |=> bus_cmd_valid && $stable(bus_cmd_addr))
        else begin
            $error("bus command dropped before bus_cmd_ready");
            violations++;
        end

    // fetch response waits for the core
    rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err))
        else begin
            $error("fetch response dropped before rsp_ready");
            violations++;
        end

    // path switch only when drained
    mode_drained: assert property (@(posedge clk) disable iff (!rstn)
        (mode != $past(mode)) |-> ($past(out_cnt) == '0))
        else begin
            $error("route mode changed with fetches outstanding");
            violations++;
        end

endmodule

// File: testbench/icb_mem_model.sv
`timescale 1ns/100ps
module icb_mem_model (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        bus_cmd_valid,
    output logic                        bus_cmd_ready,
    input  logic [icb_pkg::addr_w-1:0]  bus_cmd_addr,
    output logic                        bus_rsp_valid,
    output logic [icb_pkg::bus_dw-1:0]  bus_rsp_rdata,
    output logic                        bus_rsp_err,
    output int                          read_count
);

    logic [icb_pkg::addr_w-1:0] pend [$];   // accepted reads, answered in order
    logic [icb_pkg::addr_w-1:0] beat_addr;
    logic [31:0]                rng;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        rng           = 32'd90;
        read_count    = 0;
        bus_cmd_ready = 1'b0;
        bus_rsp_valid = 1'b0;
        bus_rsp_rdata = '0;
        bus_rsp_err   = 1'b0;
    end

    // command side, sampled on the rising edge
    always @(posedge clk) begin
        if (rstn && bus_cmd_valid && bus_cmd_ready) begin
            pend.push_back(bus_cmd_addr);
            read_count++;
        end
    end

    ////////////////////
    // driven on falling edge
    ////////////////////
    always @(negedge clk) begin
        if (!rstn) begin
            bus_cmd_ready = 1'b0;
            bus_rsp_valid = 1'b0;
        end else begin
            rng           = lcg_step(rng);
            bus_cmd_ready = (rng[17:16] != 2'b00); // stall one cycle in four
            bus_rsp_valid = 1'b0;
            if (pend.size() > 0 && rng[19:18] != 2'b00) begin
                beat_addr     = pend.pop_front();
                bus_rsp_valid = 1'b1;
                bus_rsp_rdata = {~(beat_addr + 32'd4), ~beat_addr}; // each word is its address inverted
                bus_rsp_err   = (beat_addr >= 32'hF000_0000);        // top region faults
            end
        end
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/100ps
module icache_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic [icb_pkg::addr_w-1:0]  cmd_addr,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [icb_pkg::word_w-1:0]  rsp_rdata,
    output logic                        rsp_err,
    output logic                        bus_cmd_valid,
    input  logic                        bus_cmd_ready,
    output logic [icb_pkg::addr_w-1:0]  bus_cmd_addr,
    input  logic                        bus_rsp_valid,
    input  logic [icb_pkg::bus_dw-1:0]  bus_rsp_rdata,
    input  logic                        bus_rsp_err
);

    // route to lookup, data back to route
    logic                              lk_valid, lk_ready;
    logic [icb_pkg::addr_w-1:0]        lk_addr;
    logic                              dt_valid, dt_ready, dt_err;
    logic [icb_pkg::word_w-1:0]        dt_rdata;

    // refill bus side
    logic                              rf_idle_flag, rf_cmd_valid, rf_cmd_ready, rf_rsp_valid;
    logic [icb_pkg::addr_w-1:0]        rf_cmd_addr;

    // lookup to data, miss handshake
    logic                              hd_valid, hd_ready, err_valid, miss_req;
    logic [icache_pkg::way_w-1:0]      hd_way, miss_way;
    logic [icb_pkg::addr_w-1:0]        hd_addr, miss_addr;
    logic                              fill_tag_we, fill_we, fill_done, fill_err;
    logic [icache_pkg::line_w-1:0]     fill_line;

    ////////////////////
    // stages
    ////////////////////
    icache_route  u_route  (.*); // path split and bus owner
    icache_lookup u_lookup (.*); // tags, hit or miss
    icache_refill u_refill (.*); // four beat line fetch
    icache_data   u_data   (.*); // line array and output reg

endmodule

// File: source/icache_data.sv
`timescale 1ns/100ps
module icache_data (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            hd_valid,
    output logic                            hd_ready,
    input  logic [icache_pkg::way_w-1:0]    hd_way,
    input  logic [icb_pkg::addr_w-1:0]      hd_addr,
    input  logic                            err_valid,
    input  logic                            fill_we,
    input  logic [icache_pkg::line_w-1:0]   fill_line,
    input  logic [icache_pkg::way_w-1:0]    miss_way,
    input  logic [icb_pkg::addr_w-1:0]      miss_addr,
    output logic                            dt_valid,
    input  logic                            dt_ready,
    output logic [icb_pkg::word_w-1:0]      dt_rdata,
    output logic                            dt_err
);

    logic [icache_pkg::line_w-1:0] data_mem [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::line_w-1:0] rd_line;
    logic                          hd_fire;

    ////////////////////
    // line storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (fill_we)
            data_mem[miss_way][miss_addr[icache_pkg::off_w +: icache_pkg::idx_w]] <= fill_line;
    end

    assign rd_line = data_mem[hd_way][hd_addr[icache_pkg::off_w +: icache_pkg::idx_w]];

    // output register, holds while fetch side stalls
    assign hd_ready = ~dt_valid | dt_ready;
    assign hd_fire  = hd_valid & hd_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            dt_valid <= 1'b0;
        else if (hd_ready)
            dt_valid <= hd_valid;
    end

    always_ff @(posedge clk) begin
        if (hd_fire) begin
            dt_rdata <= rd_line[hd_addr[icache_pkg::off_w-1:2]*icb_pkg::word_w +: icb_pkg::word_w];
            dt_err   <= err_valid; // word is don't care on error
        end
    end

endmodule

// File: source/icache_refill.sv
`timescale 1ns/100ps
module icache_refill (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              miss_req,
    input  logic [icb_pkg::addr_w-1:0]        miss_addr,
    input  logic [icache_pkg::way_w-1:0]      miss_way,
    output logic                              rf_cmd_valid,
    input  logic                              rf_cmd_ready,
    output logic [icb_pkg::addr_w-1:0]        rf_cmd_addr,
    input  logic                              rf_rsp_valid,
    input  logic [icb_pkg::bus_dw-1:0]        bus_rsp_rdata,
    input  logic                              bus_rsp_err,
    output logic                              fill_tag_we,
    output logic                              fill_we,
    output logic [icache_pkg::line_w-1:0]     fill_line,
    output logic                              fill_done,
    output logic                              fill_err,
    output logic                              rf_idle_flag
);

    icache_pkg::refill_state_e state;
    logic [1:0]                                        beat;      // beat in flight
    logic                                              beat_err;  // sticky over the line
    logic                                              way_ok, fill_ok;
    logic [icache_pkg::way_w-1:0]                      fill_way;
    logic [icb_pkg::addr_w-icache_pkg::off_w-1:0]      line_base;
    logic [icache_pkg::line_w-1:0]                     line_buf;

    ////////////////////
    // miss fsm
    ////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= icache_pkg::rf_idle;
            beat     <= '0;
            beat_err <= 1'b0;
        end else begin
            case (state)
                icache_pkg::rf_idle: begin
                    if (miss_req) begin
                        state    <= icache_pkg::rf_req;
                        beat     <= '0;
                        beat_err <= 1'b0;
                    end
                end
                icache_pkg::rf_req: begin
                    if (rf_cmd_ready)
                        state <= icache_pkg::rf_wait;
                end
                icache_pkg::rf_wait: begin
                    if (rf_rsp_valid) begin
                        beat_err <= beat_err | bus_rsp_err;
                        if (beat == 2'(icb_pkg::beats - 1)) begin
                            state <= icache_pkg::rf_fill;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= icache_pkg::rf_req;
                        end
                    end
                end
                icache_pkg::rf_fill: state <= icache_pkg::rf_idle; // one cycle write
                default:             state <= icache_pkg::rf_idle;
            endcase
        end
    end

    // line address and victim taken at miss start
    always_ff @(posedge clk) begin
        if ((state == icache_pkg::rf_idle) && miss_req) begin
            line_base <= miss_addr[icb_pkg::addr_w-1:icache_pkg::off_w];
            fill_way  <= miss_way;
        end
        if ((state == icache_pkg::rf_wait) && rf_rsp_valid)
            line_buf[beat*icb_pkg::bus_dw +: icb_pkg::bus_dw] <= bus_rsp_rdata;
    end

    assign rf_cmd_valid = (state == icache_pkg::rf_req);
    assign rf_cmd_addr  = {line_base, beat, 3'b000}; // +0 +8 +16 +24
    assign rf_idle_flag = (state == icache_pkg::rf_idle);

    ////////////////////
    // fill outputs
    ////////////////////
    // victim must not move while the line is fetched
    assign way_ok  = (fill_way == miss_way);
    assign fill_ok = (state == icache_pkg::rf_fill) & ~beat_err & way_ok;

    assign fill_line   = line_buf;
    assign fill_we     = fill_ok;  // bad beat never reaches the data array
    assign fill_tag_we = fill_ok;
    assign fill_done   = fill_ok;
    assign fill_err    = (state == icache_pkg::rf_fill) & (beat_err | ~way_ok);

endmodule

// File: source/icache_lookup.sv
`timescale 1ns/100ps
module icache_lookup (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             lk_valid,
    output logic                             lk_ready,
    input  logic [icb_pkg::addr_w-1:0]       lk_addr,
    output logic                             hd_valid,
    input  logic                             hd_ready,
    output logic [icache_pkg::way_w-1:0]     hd_way,
    output logic [icb_pkg::addr_w-1:0]       hd_addr,
    output logic                             miss_req,
    output logic [icb_pkg::addr_w-1:0]       miss_addr,
    output logic [icache_pkg::way_w-1:0]     miss_way,
    input  logic                             fill_tag_we,
    input  logic                             fill_done,
    input  logic                             fill_err,
    output logic                             err_valid
);

    logic                               req_valid, err_pend, hit;
    logic [icb_pkg::addr_w-1:0]         req_addr;
    logic [icache_pkg::idx_w-1:0]       idx;
    logic [icache_pkg::tag_w-1:0]       tag;
    logic [icache_pkg::way_w-1:0]       hit_way;
    logic [icache_pkg::tag_w-1:0]       tag_mem [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_sets-1:0]    vld [icache_pkg::num_ways];
    logic [icache_pkg::way_w-1:0]       rr_ptr [icache_pkg::num_sets]; // next victim per set

    assign idx = req_addr[icache_pkg::off_w +: icache_pkg::idx_w];
    assign tag = req_addr[icache_pkg::off_w + icache_pkg::idx_w +: icache_pkg::tag_w];

    ////////////////////
    // hit compare
    ////////////////////
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (vld[w][idx] && (tag_mem[w][idx] == tag)) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_w'(w);
            end
        end
    end

    // error marker goes down the hit path, line stays invalid
    assign hd_valid  = req_valid & (hit | err_pend);
    assign hd_way    = hit_way;
    assign hd_addr   = req_addr;
    assign err_valid = err_pend;
    assign lk_ready  = ~req_valid | (hd_valid & hd_ready);

    // miss holds the register until refill answers
    assign miss_req  = req_valid & ~hit & ~err_pend;
    assign miss_addr = req_addr;
    assign miss_way  = rr_ptr[idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_valid <= 1'b0;
            err_pend  <= 1'b0;
        end else if (lk_ready) begin
            req_valid <= lk_valid;
            err_pend  <= 1'b0;
        end else if (fill_err) begin
            err_pend  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lk_ready && lk_valid)
            req_addr <= lk_addr;
        if (fill_tag_we)
            tag_mem[miss_way][idx] <= tag;
    end

    ////////////////////
    // valid and victim
    ////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < icache_pkg::num_ways; w++)
                vld[w] <= '0;
            for (int s = 0; s < icache_pkg::num_sets; s++)
                rr_ptr[s] <= '0;
        end else begin
            if (fill_tag_we)
                vld[miss_way][idx] <= 1'b1;
            if (fill_done)                   // compare reruns next cycle and hits
                rr_ptr[idx] <= rr_ptr[idx] + 1'b1;
        end
    end

endmodule

// File: source/icache_route.sv
`timescale 1ns/100ps
module icache_route (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic [icb_pkg::addr_w-1:0]  cmd_addr,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [icb_pkg::word_w-1:0]  rsp_rdata,
    output logic                        rsp_err,
    output logic                        lk_valid,
    input  logic                        lk_ready,
    output logic [icb_pkg::addr_w-1:0]  lk_addr,
    input  logic                        dt_valid,
    output logic                        dt_ready,
    input  logic [icb_pkg::word_w-1:0]  dt_rdata,
    input  logic                        dt_err,
    input  logic                        rf_idle_flag,
    input  logic                        rf_cmd_valid,
    output logic                        rf_cmd_ready,
    input  logic [icb_pkg::addr_w-1:0]  rf_cmd_addr,
    output logic                        rf_rsp_valid,
    output logic                        bus_cmd_valid,
    input  logic                        bus_cmd_ready,
    output logic [icb_pkg::addr_w-1:0]  bus_cmd_addr,
    input  logic                        bus_rsp_valid,
    input  logic [icb_pkg::bus_dw-1:0]  bus_rsp_rdata,
    input  logic                        bus_rsp_err
);

    icache_pkg::route_state_e mode, mode_nxt;
    logic [icb_pkg::out_w-1:0] out_cnt;       // accepted, not yet answered
    logic                      unc_hit, drained, cmd_fire, rsp_fire;
    logic                      unc_room, unc_cmd_valid, unc_bus_rsp, in_unc;
    logic [1:0]                b2_fifo;       // addr[2] per uncached read
    logic                      b2_wp, b2_rp;
    logic                      unc_rsp_valid, unc_rsp_err;
    logic [icb_pkg::word_w-1:0] unc_rsp_word;

    assign unc_hit  = (cmd_addr >= icb_pkg::unc_begin) && (cmd_addr <= icb_pkg::unc_end);
    assign drained  = (out_cnt == '0);
    assign cmd_fire = cmd_valid & cmd_ready;
    assign rsp_fire = rsp_valid & rsp_ready;
    assign in_unc   = (mode == icache_pkg::uncache);

    ////////////////////
    // mode fsm
    ////////////////////
    always_comb begin
        mode_nxt = mode;
        case (mode)
            icache_pkg::idle: begin
                if (cmd_valid)
                    mode_nxt = unc_hit ? icache_pkg::uncache : icache_pkg::cache;
            end
            icache_pkg::cache: begin // refill must be quiet too
                if (cmd_valid && unc_hit && drained && rf_idle_flag)
                    mode_nxt = icache_pkg::uncache;
            end
            icache_pkg::uncache: begin
                if (cmd_valid && !unc_hit && drained)
                    mode_nxt = icache_pkg::cache;
            end
            default: mode_nxt = icache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode    <= icache_pkg::idle;
            out_cnt <= '0;
        end else begin
            mode <= mode_nxt;
            if (cmd_fire && !rsp_fire)
                out_cnt <= out_cnt + 1'b1;
            else if (!cmd_fire && rsp_fire)
                out_cnt <= out_cnt - 1'b1;
        end
    end

    // fetch command steering, nothing taken in idle
    assign lk_valid = cmd_valid & (mode == icache_pkg::cache) & ~unc_hit;
    assign lk_addr  = cmd_addr;

    always_comb begin
        case (mode)
            icache_pkg::cache:   cmd_ready = lk_ready & ~unc_hit;
            icache_pkg::uncache: cmd_ready = bus_cmd_ready & unc_hit & unc_room;
            default:             cmd_ready = 1'b0;
        endcase
    end

    ////////////////////
    // uncached path
    ////////////////////
    // one read at a time, next one may go out as the last answer leaves
    assign unc_room      = drained | ((out_cnt == 1) & rsp_fire);
    assign unc_cmd_valid = cmd_valid & unc_hit & in_unc & unc_room;
    assign unc_bus_rsp   = bus_rsp_valid & in_unc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            b2_wp         <= 1'b0;
            b2_rp         <= 1'b0;
            unc_rsp_valid <= 1'b0;
        end else begin
            if (unc_cmd_valid && bus_cmd_ready)
                b2_wp <= ~b2_wp;
            if (unc_bus_rsp)
                b2_rp <= ~b2_rp;
            unc_rsp_valid <= unc_bus_rsp | (unc_rsp_valid & ~rsp_ready); // hold till taken
        end
    end

    always_ff @(posedge clk) begin
        if (unc_cmd_valid && bus_cmd_ready)
            b2_fifo[b2_wp] <= cmd_addr[2];
        if (unc_bus_rsp) begin
            unc_rsp_word <= b2_fifo[b2_rp] ? bus_rsp_rdata[icb_pkg::word_w +: icb_pkg::word_w]
                                           : bus_rsp_rdata[0 +: icb_pkg::word_w];
            unc_rsp_err  <= bus_rsp_err;
        end
    end

    // response merge
    assign rsp_valid = in_unc ? unc_rsp_valid : dt_valid;
    assign rsp_rdata = in_unc ? unc_rsp_word  : dt_rdata;
    assign rsp_err   = in_unc ? unc_rsp_err   : dt_err;
    assign dt_ready  = rsp_ready & ~in_unc;

    // single bus port, owner follows mode
    assign bus_cmd_valid = in_unc ? unc_cmd_valid : rf_cmd_valid;
    assign bus_cmd_addr  = in_unc ? {cmd_addr[icb_pkg::addr_w-1:3], 3'b000} : rf_cmd_addr;
    assign rf_cmd_ready  = bus_cmd_ready & ~in_unc;
    assign rf_rsp_valid  = bus_rsp_valid & ~in_unc;

endmodule

// File: source/icb_pkg.sv
// system bus and fetch side widths
package icb_pkg;

    localparam int addr_w = 32;
    localparam int bus_dw = 64;  // one beat
    localparam int word_w = 32;  // instruction word
    localparam int beats  = 4;   // beats per cache line
    localparam int out_w  = 4;   // outstanding fetch counter

    // low region bypasses the cache
    localparam logic [31:0] unc_begin = 32'h0000_0000;
    localparam logic [31:0] unc_end   = 32'h0000_0FFF;

endpackage

// File: source/icache_pkg.sv
// cache geometry, 16KB 4-way, 32B lines
package icache_pkg;

    ////////////////////
    // geometry
    ////////////////////
    localparam int off_w    = 5;   // byte in line
    localparam int idx_w    = 7;   // set select
    localparam int tag_w    = 20;  // 32 - 7 - 5
    localparam int num_ways = 4;
    localparam int num_sets = 128; // 4KB per way / 32B
    localparam int way_w    = 2;
    localparam int line_w   = 256; // four 64-bit beats

    ////////////////////
    // fsm encodings
    ////////////////////

    // router mode, which path owns the bus
    typedef enum logic [1:0] {
        idle    = 2'd0,
        cache   = 2'd1,
        uncache = 2'd2
    } route_state_e;

    // miss handler
    typedef enum logic [1:0] {
        rf_idle = 2'd0,
        rf_req  = 2'd1, // beat read on the bus
        rf_wait = 2'd2, // waiting for the beat
        rf_fill = 2'd3  // line complete, write arrays
    } refill_state_e;

endpackage
